// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // fetch exception codes in check order
    typedef enum logic [1:0] {
        EXC_NONE       = 2'd0,
        EXC_ADEF_ALIGN = 2'd1,
        EXC_ADEF_PLV   = 2'd2
    } excp_code_e;

    typedef enum logic {
        FETCH = 1'b0,
        HALT  = 1'b1
    } fetch_state_e;

    // one queued instruction of 100 bits
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] npc;
        logic [1:0]  plv;
        excp_code_e  excp;
    } fetch_entry_t;

    localparam logic [1:0] PLV_USER = 2'd3;

    localparam logic [31:0] INST_BYTES = 32'd4;
    localparam logic [31:0] PAIR_BYTES = 32'd8;

    // free entries the buffer needs before another fetch goes out
    localparam int FB_READY_FREE = 4;

endpackage

// ==== logic/fetch_if.sv ====
interface fetch_if import fetch_pkg::*; ();

    logic        valid;
    // both ir_lo and ir_hi hold instructions
    logic        pair;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] ir_lo;
    logic [31:0] ir_hi;
    logic [1:0]  plv;
    excp_code_e  excp;

    modport mem (
        output valid,
        output pair,
        output pc,
        output npc,
        output ir_lo,
        output ir_hi,
        output plv,
        output excp
    );

    modport buff (
        input valid,
        input pair,
        input pc,
        input npc,
        input ir_lo,
        input ir_hi,
        input plv,
        input excp
    );

endinterface

// ==== logic/pc_gen.sv ====
module pc_gen import fetch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic [1:0]  plv,
    input  logic        fetch_ready,
    output logic        req,
    output logic [31:0] req_pc,
    output logic [1:0]  req_plv,
    output excp_code_e  req_excp
);

    fetch_state_e state;
    logic [31:0]  pc;
    logic [31:0]  next_pc;

    // a pair from an even word, a single from an odd one
    assign next_pc = pc[2] ? pc + INST_BYTES : pc + PAIR_BYTES;

    // alignment wins over privilege
    always_comb begin
        if (pc[1:0] != 2'b00) begin
            req_excp = EXC_ADEF_ALIGN;
        end else if (plv == PLV_USER && pc[31]) begin
            req_excp = EXC_ADEF_PLV;
        end else begin
            req_excp = EXC_NONE;
        end
    end

    assign req     = state == FETCH && fetch_ready && !flush;
    assign req_pc  = pc;
    assign req_plv = plv;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else if (flush) begin
            state <= FETCH;
            pc    <= flush_pc;
        end else if (req) begin
            if (req_excp != EXC_NONE) begin
                state <= HALT;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // one faulting fetch, then silence until redirected
    assert property (@(posedge clk) disable iff (rst)
        req && req_excp != EXC_NONE |=> !req);

endmodule

// ==== logic/inst_mem.sv ====
module inst_mem import fetch_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    input  logic                         req,
    input  logic [31:0]                  req_pc,
    input  logic [1:0]                   req_plv,
    input  excp_code_e                   req_excp,
    fetch_if.mem                         rsp
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] idx_lo;
    logic [AW-1:0] idx_hi;
    logic [31:0]   word_lo;
    logic [31:0]   word_hi;
    logic          req_ok;
    logic          rsp_ok;

    // even and odd word of the pair wrap with the array size
    assign idx_lo = {req_pc[AW+1:3], 1'b0};
    assign idx_hi = {req_pc[AW+1:3], 1'b1};
    assign req_ok = req_excp == EXC_NONE;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (req) begin
            word_lo  <= mem[idx_lo];
            word_hi  <= mem[idx_hi];
            rsp.pc   <= req_pc;
            rsp.plv  <= req_plv;
            rsp.excp <= req_excp;
            rsp.pair <= req_ok && !req_pc[2];
            if (!req_ok) begin
                rsp.npc <= req_pc;
            end else if (req_pc[2]) begin
                rsp.npc <= req_pc + INST_BYTES;
            end else begin
                rsp.npc <= req_pc + PAIR_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req;
        end
    end

    assign rsp_ok = rsp.excp == EXC_NONE;

    // odd start puts the odd word in the first entry
    assign rsp.ir_lo = !rsp_ok ? 32'd0 : (rsp.pc[2] ? word_hi : word_lo);
    assign rsp.ir_hi = rsp_ok ? word_hi : 32'd0;

endmodule

// ==== logic/fetch_buffer.sv ====
module fetch_buffer import fetch_pkg::*; #(
    parameter int FB_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         take0,
    input  logic         take1,
    fetch_if.buff        rsp,
    output logic         fetch_ready,
    output fetch_entry_t out0,
    output fetch_entry_t out1,
    output logic         out0_valid,
    output logic         out1_valid
);

    localparam int PW = $clog2(FB_DEPTH);
    localparam logic [PW:0] READY_MAX = (PW + 1)'(FB_DEPTH - FB_READY_FREE);

    fetch_entry_t  q [FB_DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] head_p1;
    logic [PW-1:0] tail;
    logic [PW-1:0] tail_p1;
    logic [PW:0]   count;
    logic [1:0]    push_n;
    logic [1:0]    pop_n;
    fetch_entry_t  entry_lo;
    fetch_entry_t  entry_hi;

    // pointers wrap on their own since depth is a power of two
    assign head_p1 = head + 1'b1;
    assign tail_p1 = tail + 1'b1;

    assign push_n = rsp.valid ? (rsp.pair ? 2'd2 : 2'd1) : 2'd0;
    assign pop_n  = take0 ? (take1 ? 2'd2 : 2'd1) : 2'd0;

    assign entry_lo = '{
        pc:   rsp.pc,
        ir:   rsp.ir_lo,
        npc:  rsp.npc,
        plv:  rsp.plv,
        excp: rsp.excp
    };

    // second half of a pair never faults
    assign entry_hi = '{
        pc:   rsp.pc + INST_BYTES,
        ir:   rsp.ir_hi,
        npc:  rsp.npc,
        plv:  rsp.plv,
        excp: EXC_NONE
    };

    always_ff @(posedge clk) begin
        if (rsp.valid && !flush) begin
            q[tail] <= entry_lo;
            if (rsp.pair) begin
                q[tail_p1] <= entry_hi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PW'(pop_n);
            tail  <= tail + PW'(push_n);
            count <= count + (PW + 1)'(push_n) - (PW + 1)'(pop_n);
        end
    end

    assign out0       = q[head];
    assign out1       = q[head_p1];
    assign out0_valid = count != '0;
    assign out1_valid = count > (PW + 1)'(1);

    // room for the pair still in flight from memory
    assign fetch_ready = count <= READY_MAX;

    assert property (@(posedge clk) disable iff (rst)
        take1 |-> take0);

    // decode must only take what it was shown
    assert property (@(posedge clk) disable iff (rst)
        !((take0 && !out0_valid) || (take1 && !out1_valid)));

    assert property (@(posedge clk) disable iff (rst)
        count <= (PW + 1)'(FB_DEPTH));

endmodule

// ==== logic/fetch_frontend.sv ====
module fetch_frontend import fetch_pkg::*; #(
    parameter logic [31:0] RESET_PC  = 32'h0000_0000,
    parameter int          MEM_WORDS = 256,
    parameter int          FB_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic [31:0]                  flush_pc,
    input  logic [1:0]                   plv,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    input  logic                         take0,
    input  logic                         take1,
    output logic                         out0_valid,
    output logic [31:0]                  out0_pc,
    output logic [31:0]                  out0_ir,
    output logic [31:0]                  out0_npc,
    output logic [1:0]                   out0_plv,
    output excp_code_e                   out0_excp,
    output logic                         out1_valid,
    output logic [31:0]                  out1_pc,
    output logic [31:0]                  out1_ir,
    output logic [31:0]                  out1_npc,
    output logic [1:0]                   out1_plv,
    output excp_code_e                   out1_excp
);

    logic         req;
    logic [31:0]  req_pc;
    logic [1:0]   req_plv;
    excp_code_e   req_excp;
    logic         fetch_ready;
    fetch_entry_t out0;
    fetch_entry_t out1;

    fetch_if fetch_rsp ();

    pc_gen #(.RESET_PC(RESET_PC)) pc_gen_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .plv         (plv),
        .fetch_ready (fetch_ready),
        .req         (req),
        .req_pc      (req_pc),
        .req_plv     (req_plv),
        .req_excp    (req_excp)
    );

    inst_mem #(.MEM_WORDS(MEM_WORDS)) inst_mem_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .req       (req),
        .req_pc    (req_pc),
        .req_plv   (req_plv),
        .req_excp  (req_excp),
        .rsp       (fetch_rsp.mem)
    );

    fetch_buffer #(.FB_DEPTH(FB_DEPTH)) fetch_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .take0       (take0),
        .take1       (take1),
        .rsp         (fetch_rsp.buff),
        .fetch_ready (fetch_ready),
        .out0        (out0),
        .out1        (out1),
        .out0_valid  (out0_valid),
        .out1_valid  (out1_valid)
    );

    // slot 0 is the oldest entry
    assign out0_pc   = out0.pc;
    assign out0_ir   = out0.ir;
    assign out0_npc  = out0.npc;
    assign out0_plv  = out0.plv;
    assign out0_excp = out0.excp;

    assign out1_pc   = out1.pc;
    assign out1_ir   = out1.ir;
    assign out1_npc  = out1.npc;
    assign out1_plv  = out1.plv;
    assign out1_excp = out1.excp;

endmodule

// ==== bench/clk_rst_gen.sv ====
module clk_rst_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== bench/fetch_frontend_tb.sv ====
module fetch_frontend_tb import fetch_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          MEM_WORDS    = 256;
    localparam int          FB_DEPTH     = 16;
    localparam int          AW           = $clog2(MEM_WORDS);
    localparam logic [31:0] LFSR_SEED    = 32'hf926_4b7b;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam int          STEP_LIMIT   = 200;
    localparam int          WAIT_LIMIT   = 50;
    // reset, five memory loads, then the streams themselves
    localparam int          LOAD_CYCLES  = MEM_WORDS + 2;
    localparam int          TEST_CYCLES  = RESET_CYCLES + 5 * LOAD_CYCLES + 1000;
    localparam int          WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 2;

    logic            clk;
    logic            rst;
    logic            flush;
    logic [31:0]     flush_pc;
    logic [1:0]      plv;
    logic            load_en;
    logic [AW-1:0]   load_addr;
    logic [31:0]     load_data;
    logic            take0;
    logic            take1;
    logic            out0_valid;
    logic [31:0]     out0_pc;
    logic [31:0]     out0_ir;
    logic [31:0]     out0_npc;
    logic [1:0]      out0_plv;
    excp_code_e      out0_excp;
    logic            out1_valid;
    logic [31:0]     out1_pc;
    logic [31:0]     out1_ir;
    logic [31:0]     out1_npc;
    logic [1:0]      out1_plv;
    excp_code_e      out1_excp;

    // reference model state
    logic [31:0]     ref_mem [MEM_WORDS];
    fetch_entry_t    exp_q [$];
    logic [31:0]     model_pc;
    logic            model_halted;
    logic [1:0]      cur_plv;
    logic [31:0]     lfsr_state;

    clk_rst_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_rst_i (
        .clk (clk),
        .rst (rst)
    );

    fetch_frontend #(
        .RESET_PC  (32'h0000_0000),
        .MEM_WORDS (MEM_WORDS),
        .FB_DEPTH  (FB_DEPTH)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .plv        (plv),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .take0      (take0),
        .take1      (take1),
        .out0_valid (out0_valid),
        .out0_pc    (out0_pc),
        .out0_ir    (out0_ir),
        .out0_npc   (out0_npc),
        .out0_plv   (out0_plv),
        .out0_excp  (out0_excp),
        .out1_valid (out1_valid),
        .out1_pc    (out1_pc),
        .out1_ir    (out1_ir),
        .out1_npc   (out1_npc),
        .out1_plv   (out1_plv),
        .out1_excp  (out1_excp)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                      $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected entries of one fetch at the model pc
    task automatic predict_fetch();
        fetch_entry_t e;
        int           w;
        e.pc  = model_pc;
        e.plv = cur_plv;
        if (model_pc[1:0] != 2'b00) begin
            e.excp = EXC_ADEF_ALIGN;
        end else if (cur_plv == PLV_USER && model_pc[31]) begin
            e.excp = EXC_ADEF_PLV;
        end else begin
            e.excp = EXC_NONE;
        end
        w = int'(model_pc[31:2]) % MEM_WORDS;
        if (e.excp != EXC_NONE) begin
            e.ir  = 32'd0;
            e.npc = model_pc;
            exp_q.push_back(e);
            model_halted = 1'b1;
        end else if (!model_pc[2]) begin
            e.ir  = ref_mem[w];
            e.npc = model_pc + 32'd8;
            exp_q.push_back(e);
            e.pc  = model_pc + 32'd4;
            e.ir  = ref_mem[(w + 1) % MEM_WORDS];
            exp_q.push_back(e);
            model_pc = model_pc + 32'd8;
        end else begin
            e.ir  = ref_mem[w];
            e.npc = model_pc + 32'd4;
            exp_q.push_back(e);
            model_pc = model_pc + 32'd4;
        end
    endtask

    task automatic pop_expected(output fetch_entry_t e);
        while (exp_q.size() == 0 && !model_halted) begin
            predict_fetch();
        end
        if (exp_q.size() == 0) begin
            stop_with_error("an entry arrived after a fetch exception");
        end
        e = exp_q.pop_front();
    endtask

    function automatic fetch_entry_t slot_entry(input int k);
        fetch_entry_t e;
        e.pc   = (k == 0) ? out0_pc : out1_pc;
        e.ir   = (k == 0) ? out0_ir : out1_ir;
        e.npc  = (k == 0) ? out0_npc : out1_npc;
        e.plv  = (k == 0) ? out0_plv : out1_plv;
        e.excp = (k == 0) ? out0_excp : out1_excp;
        return e;
    endfunction

    task automatic compare_entry(input int k, input fetch_entry_t got,
                                 input fetch_entry_t exp);
        check($sformatf("out%0d_pc", k), got.pc, exp.pc);
        check($sformatf("out%0d_ir", k), got.ir, exp.ir);
        check($sformatf("out%0d_npc", k), got.npc, exp.npc);
        check($sformatf("out%0d_plv", k), 32'(got.plv), 32'(exp.plv));
        check($sformatf("out%0d_excp", k), 32'(got.excp), 32'(exp.excp));
    endtask

    // slots are read in a cycle without takes, so they hold still for the take cycle
    task automatic take_step(input int max_take, output int taken);
        int           avail;
        int           n;
        fetch_entry_t exp;
        @(negedge clk);
        avail = out1_valid ? 2 : (out0_valid ? 1 : 0);
        n = (max_take < avail) ? max_take : avail;
        for (int k = 0; k < n; k++) begin
            pop_expected(exp);
            compare_entry(k, slot_entry(k), exp);
        end
        @(posedge clk);
        take0 <= n >= 1;
        take1 <= n == 2;
        @(posedge clk);
        take0 <= 1'b0;
        take1 <= 1'b0;
        taken = n;
    endtask

    task automatic take_entries(input int count, input bit random_takes);
        int done;
        int steps;
        int n;
        int max_take;
        done  = 0;
        steps = 0;
        while (done < count) begin
            if (steps == STEP_LIMIT) begin
                stop_with_error("fetch stopped delivering entries");
            end
            max_take = random_takes ? int'(rand_bits(2) % 32'd3) : 2;
            take_step(max_take, n);
            done  = done + n;
            steps = steps + 1;
        end
    endtask

    task automatic wait_for_entry();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!out0_valid) begin
            if (cycles == WAIT_LIMIT) begin
                stop_with_error("no entry reached slot 0 after a flush");
            end
            cycles = cycles + 1;
            @(negedge clk);
        end
    endtask

    task automatic load_memory();
        logic [31:0] word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word = rand_bits(32);
            ref_mem[i] = word;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= AW'(i);
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic flush_to(input logic [31:0] pc, input logic [1:0] level);
        @(posedge clk);
        flush    <= 1'b1;
        flush_pc <= pc;
        plv      <= level;
        take0    <= 1'b0;
        take1    <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        exp_q.delete();
        model_pc     = pc;
        model_halted = 1'b0;
        cur_plv      = level;
    endtask

    task automatic check_after_reset();
        @(negedge rst);
        repeat (2) begin
            @(negedge clk);
            check("out0_valid", 32'(out0_valid), 32'd0);
            check("out1_valid", 32'(out1_valid), 32'd0);
        end
    endtask

    task automatic fetch_aligned_stream();
        load_memory();
        flush_to(32'h0000_0040, 2'd0);
        take_entries(40, 1'b0);
    endtask

    task automatic fetch_unaligned_start();
        load_memory();
        flush_to(32'h0000_0044, 2'd0);
        wait_for_entry();
        check("out0_pc", out0_pc, 32'h0000_0044);
        check("out0_npc", out0_npc, 32'h0000_0048);
        take_entries(30, 1'b0);
    endtask

    task automatic hold_back_pressure();
        load_memory();
        flush_to(32'h0000_0080, 2'd0);
        repeat (40) @(posedge clk);
        take_entries(60, 1'b1);
    endtask

    task automatic flush_mid_stream();
        load_memory();
        flush_to(32'h0000_0100, 2'd0);
        take_entries(10, 1'b0);
        // leftovers of the old stream would break the new pc sequence
        flush_to(32'h0000_0200, 2'd0);
        take_entries(20, 1'b0);
    endtask

    task automatic raise_fetch_exceptions();
        load_memory();
        flush_to(32'h0000_0042, 2'd0);
        wait_for_entry();
        check("out0_excp", 32'(out0_excp), 32'(EXC_ADEF_ALIGN));
        check("out0_ir", out0_ir, 32'd0);
        take_entries(1, 1'b0);
        repeat (20) begin
            @(negedge clk);
            check("out0_valid", 32'(out0_valid), 32'd0);
        end
        flush_to(32'h8000_0000, PLV_USER);
        wait_for_entry();
        check("out0_excp", 32'(out0_excp), 32'(EXC_ADEF_PLV));
        take_entries(1, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("watchdog expired before the tests finished");
    end

    initial begin
        flush        = 1'b0;
        flush_pc     = 32'd0;
        plv          = 2'd0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = 32'd0;
        take0        = 1'b0;
        take1        = 1'b0;
        cur_plv      = 2'd0;
        model_pc     = 32'd0;
        model_halted = 1'b1;
        lfsr_state   = LFSR_SEED;

        check_after_reset();
        fetch_aligned_stream();
        fetch_unaligned_start();
        hold_back_pressure();
        flush_mid_stream();
        raise_fetch_exceptions();

        $display("test passed");
        $finish;
    end

endmodule

// ==== build.f ====
logic/fetch_pkg.sv
logic/fetch_if.sv
logic/pc_gen.sv
logic/inst_mem.sv
logic/fetch_buffer.sv
logic/fetch_frontend.sv
bench/clk_rst_gen.sv
bench/fetch_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module fetch_frontend_tb -o fetch_frontend_sim

# sh has no pipefail, so the log decides the result
./obj_dir/fetch_frontend_sim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation clean"
